//--- logic/rv64_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_alu (
    input  wire rv64_pkg::op_t        op,
    input  wire [rv64_pkg::XLEN-1:0]  a,
    input  wire [rv64_pkg::XLEN-1:0]  b,
    output logic [rv64_pkg::XLEN-1:0] result
);
    import rv64_pkg::*;

    logic [5:0] shamt;

    assign shamt = b[5:0];                              // RV64 shifts use six bits

    always_comb begin
        case (op)
            // Add path also forms load, store and jalr addresses
            OP_ADD, OP_ADDI, OP_LD, OP_SD, OP_JALR: result = a + b;
            OP_SUB:  result = a - b;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = $signed(a) >>> shamt;     // Sign fill
            default: result = a + b;                    // Not consumed by other ops
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv64_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_core (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [31:0]                instruction,
    output logic [rv64_pkg::XLEN-1:0] pc,
    output logic [31:0]               ir,
    output logic                      heartbeat,
    input  wire [3:0]                 interrupt_vector,
    output logic                      interrupt_ack,
    output logic [rv64_pkg::XLEN-1:0] bus_address,
    output logic [rv64_pkg::XLEN-1:0] bus_write_data,
    output logic                      bus_write_enable,
    output logic                      bus_read_enable,
    input  wire [rv64_pkg::XLEN-1:0]  bus_read_data
);
    import rv64_pkg::*;

    op_t             op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            rd_we;
    logic [XLEN-1:0] rd_data;
    logic            csr_we;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] csr_rdata;
    logic            irq_pending;
    logic            irq_take;
    logic            mret;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic            bubble;                            // Flush the instruction in ir
    logic            ld_step;                           // Second pass of a load
    logic            execute;                           // ir retires this cycle
    logic [XLEN-1:0] exec_pc;                           // Address of the instruction in ir
    logic [XLEN-1:0] pc_rel;

    rv64_decoder u_decoder (
        .ir(ir), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .csr_addr(csr_addr)
    );

    rv64_regfile u_regfile (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .rd(rd), .rd_we(rd_we), .rd_data(rd_data)
    );

    rv64_alu u_alu (.op(op), .a(rs1_data), .b(alu_b), .result(alu_result));

    rv64_csr_trap u_csr_trap (
        .clk(clk), .reset(reset), .interrupt_vector(interrupt_vector), .csr_addr(csr_addr),
        .csr_we(csr_we), .csr_wdata(csr_wdata), .csr_rdata(csr_rdata),
        .irq_pending(irq_pending), .irq_take(irq_take), .trap_pc(exec_pc), .mret(mret),
        .mtvec(mtvec), .mepc(mepc)
    );

    assign exec_pc  = pc - 64'd4;                       // pc already one word ahead
    assign pc_rel   = exec_pc + imm;                    // AUIPC, JAL and BEQ target
    assign irq_take = !bubble && irq_pending;           // Interrupt wins over ir
    assign execute  = !bubble && !irq_pending;
    assign mret     = execute && (op == OP_MRET);
    assign csr_we   = execute && (op == OP_CSRRW || (op == OP_CSRRS && rs1 != 5'd0));
    assign csr_wdata = (op == OP_CSRRW) ? rs1_data : (csr_rdata | rs1_data);
    assign alu_b = (op == OP_ADDI || op == OP_LD || op == OP_SD || op == OP_JALR) ? imm : rs2_data;

    // Register write select
    always_comb begin
        rd_we   = execute;
        rd_data = alu_result;
        case (op)
            OP_LUI:             rd_data = imm;
            OP_AUIPC:           rd_data = pc_rel;
            OP_JAL, OP_JALR:    rd_data = pc;           // Link is exec_pc + 4
            OP_CSRRW, OP_CSRRS: rd_data = csr_rdata;    // Old CSR value
            OP_LD: begin
                rd_we   = execute && ld_step;           // Only on the second pass
                rd_data = bus_read_data;
            end
            OP_SD, OP_BEQ, OP_MRET, OP_ILLEGAL: rd_we = 1'b0;
            default: ;
        endcase
    end

    // Fetch register and heartbeat
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= NOP_INSN;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= RAM_BASE;
            bubble           <= 1'b0;
            ld_step          <= 1'b0;
            interrupt_ack    <= 1'b0;
            bus_address      <= RAM_BASE;
            bus_write_data   <= '0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
        end else begin
            pc               <= pc + 64'd4;             // Default sequential fetch
            interrupt_ack    <= 1'b0;
            bus_write_enable <= 1'b0;                   // Store strobe is a single cycle
            if (bubble) begin
                bubble <= 1'b0;                         // Load address holds here
            end else begin
                bus_address     <= RAM_BASE;
                bus_write_data  <= '0;
                bus_read_enable <= 1'b0;
                ld_step         <= 1'b0;
                if (irq_pending) begin
                    pc            <= mtvec;
                    bubble        <= 1'b1;
                    interrupt_ack <= 1'b1;
                end else begin
                    case (op)
                        OP_JAL: begin
                            pc     <= pc_rel;
                            bubble <= 1'b1;
                        end
                        OP_JALR: begin
                            pc     <= {alu_result[XLEN-1:1], 1'b0};
                            bubble <= 1'b1;
                        end
                        OP_BEQ: begin
                            if (rs1_data == rs2_data) begin
                                pc     <= pc_rel;
                                bubble <= 1'b1;
                            end
                        end
                        OP_MRET: begin
                            pc     <= mepc;
                            bubble <= 1'b1;
                        end
                        OP_SD: begin
                            bus_address      <= alu_result;
                            bus_write_data   <= rs2_data;
                            bus_write_enable <= 1'b1;
                            pc               <= pc;     // Refetch after the bubble
                            bubble           <= 1'b1;
                        end
                        OP_LD: begin
                            if (!ld_step) begin
                                bus_address     <= alu_result;
                                bus_read_enable <= 1'b1;
                                pc              <= exec_pc;   // Fetch the load again
                                bubble          <= 1'b1;
                                ld_step         <= 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rv64_csr_trap.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_csr_trap (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [3:0]                 interrupt_vector,
    input  wire [11:0]                csr_addr,
    input  wire                       csr_we,
    input  wire [rv64_pkg::XLEN-1:0]  csr_wdata,
    output logic [rv64_pkg::XLEN-1:0] csr_rdata,
    output logic                      irq_pending,
    input  wire                       irq_take,
    input  wire [rv64_pkg::XLEN-1:0]  trap_pc,
    input  wire                       mret,
    output logic [rv64_pkg::XLEN-1:0] mtvec,
    output logic [rv64_pkg::XLEN-1:0] mepc
);
    import rv64_pkg::*;

    logic            status_mie;                        // mstatus.MIE
    logic            status_mpie;                       // mstatus.MPIE
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mcause;

    // Only MIE and MPIE are implemented, the rest read as zero
    always_comb begin
        mstatus               = '0;
        mstatus[MSTATUS_MIE]  = status_mie;
        mstatus[MSTATUS_MPIE] = status_mpie;
    end

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            CSR_MTVEC:   csr_rdata = mtvec;
            default:     csr_rdata = '0;                // Unknown CSR
        endcase
    end

    assign irq_pending = (interrupt_vector == IRQ_MEXT) && status_mie;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            status_mie  <= 1'b1;                        // Interrupts enabled out of reset
            status_mpie <= 1'b0;
            mepc        <= '0;
            mcause      <= '0;
            mtvec       <= MTVEC_RESET;
        end else if (irq_take) begin
            // Trap entry
            mepc        <= trap_pc;
            mcause      <= CAUSE_MEXT;
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
        end else if (mret) begin
            status_mie  <= status_mpie;                 // Restore enable
            status_mpie <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    status_mie  <= csr_wdata[MSTATUS_MIE];
                    status_mpie <= csr_wdata[MSTATUS_MPIE];
                end
                CSR_MEPC:   mepc   <= {csr_wdata[XLEN-1:2], 2'b00};   // Word aligned
                CSR_MCAUSE: mcause <= csr_wdata;
                CSR_MTVEC:  mtvec  <= {csr_wdata[XLEN-1:2], 2'b00};   // Direct mode only
                default: ;                              // Write dropped
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/rv64_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_decoder (
    input  wire [31:0]                ir,
    output rv64_pkg::op_t             op,
    output logic [4:0]                rd,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [rv64_pkg::XLEN-1:0] imm,
    output logic [11:0]               csr_addr
);
    import rv64_pkg::*;

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    opcode_t         opcode;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;

    assign opcode   = opcode_t'(ir[6:0]);
    assign funct3   = ir[14:12];
    assign funct7   = ir[31:25];
    assign rd       = ir[11:7];
    assign rs1      = ir[19:15];
    assign rs2      = ir[24:20];
    assign csr_addr = ir[31:20];                        // CSR index sits in the I field

    // Sign-extended immediates
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_b = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

    always_comb begin
        op  = OP_ILLEGAL;
        imm = '0;
        case (opcode)
            OPC_LUI:   begin op = OP_LUI;   imm = imm_u; end
            OPC_AUIPC: begin op = OP_AUIPC; imm = imm_u; end
            OPC_OP_IMM: begin
                imm = imm_i;
                if (funct3 == 3'b000) op = OP_ADDI;     // Only ADDI in the immediate group
            end
            OPC_OP: begin
                // funct7 picks the base or the alternate form
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = OP_ADD;
                    {7'b0100000, 3'b000}: op = OP_SUB;
                    {7'b0000000, 3'b001}: op = OP_SLL;
                    {7'b0000000, 3'b010}: op = OP_SLT;
                    {7'b0000000, 3'b011}: op = OP_SLTU;
                    {7'b0000000, 3'b100}: op = OP_XOR;
                    {7'b0000000, 3'b101}: op = OP_SRL;
                    {7'b0100000, 3'b101}: op = OP_SRA;
                    {7'b0000000, 3'b110}: op = OP_OR;
                    {7'b0000000, 3'b111}: op = OP_AND;
                    default:              op = OP_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                imm = imm_i;
                if (funct3 == 3'b011) op = OP_LD;       // Doubleword only
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == 3'b011) op = OP_SD;
            end
            OPC_JAL: begin op = OP_JAL; imm = imm_j; end
            OPC_JALR: begin
                imm = imm_i;
                if (funct3 == 3'b000) op = OP_JALR;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) op = OP_BEQ;      // Other branches are not supported
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b001)       op = OP_CSRRW;
                else if (funct3 == 3'b010)  op = OP_CSRRS;
                else if (ir == 32'h3020_0073) op = OP_MRET;
            end
            default: op = OP_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv64_pkg.sv
`default_nettype none

package rv64_pkg;

    localparam int XLEN = 64;                           // Data width

    // Memory map
    localparam logic [XLEN-1:0] RAM_BASE    = 64'h0000_0000_8000_0000;  // Reset pc, idle bus address
    localparam logic [XLEN-1:0] MTVEC_RESET = RAM_BASE + 64'h100;       // Default trap handler

    // Machine CSR indices
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;                    // Global machine interrupt enable
    localparam int MSTATUS_MPIE = 7;                    // MIE saved on trap entry

    // Interrupt flag in the MSB, cause 11 is machine external
    localparam logic [XLEN-1:0] CAUSE_MEXT = {1'b1, 59'd0, 4'd11};
    localparam logic [3:0]      IRQ_MEXT   = 4'd1;      // Only code that requests an interrupt

    localparam logic [31:0] NOP_INSN = 32'h0000_0013;   // addi x0, x0, 0

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // Decoded operation
    typedef enum logic [4:0] {
        OP_ILLEGAL,                                     // Executes as a no-op
        OP_LUI, OP_AUIPC,
        OP_ADDI,
        OP_ADD, OP_SUB,
        OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LD, OP_SD,
        OP_JAL, OP_JALR, OP_BEQ,
        OP_CSRRW, OP_CSRRS,
        OP_MRET
    } op_t;

endpackage

`default_nettype wire

//--- logic/rv64_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_regfile (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [4:0]                 rs1,
    input  wire [4:0]                 rs2,
    output logic [rv64_pkg::XLEN-1:0] rs1_data,
    output logic [rv64_pkg::XLEN-1:0] rs2_data,
    input  wire [4:0]                 rd,
    input  wire                       rd_we,
    input  wire [rv64_pkg::XLEN-1:0]  rd_data
);
    import rv64_pkg::*;

    logic [XLEN-1:0] regs [1:31];                       // x1..x31, x0 has no storage

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != 5'd0) begin         // Writes to x0 are dropped
            regs[rd] <= rd_data;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rv64_core.f
logic/rv64_pkg.sv
logic/rv64_decoder.sv
logic/rv64_regfile.sv
logic/rv64_alu.sv
logic/rv64_csr_trap.sv
logic/rv64_core.sv
verification/rv64_core_sva.sv
verification/rv64_core_tb.sv

//--- verification/rv64_core_sva.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_core_sva (
    input wire                      clk,
    input wire                      reset,
    input wire [rv64_pkg::XLEN-1:0] pc,
    input wire                      bus_write_enable,
    input wire                      bus_read_enable,
    input wire                      interrupt_ack
);

    // One bus direction at a time
    a_bus_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_write_enable && bus_read_enable))
        else $error("bus_write_enable and bus_read_enable high together");

    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack)
        else $error("interrupt_ack longer than one cycle");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!reset)
        pc[1:0] == 2'b00)                               // 32-bit instructions only
        else $error("pc not word aligned");

    a_store_single: assert property (@(posedge clk) disable iff (!reset)
        bus_write_enable |=> !bus_write_enable)
        else $error("bus_write_enable high for two cycles");

endmodule

bind rv64_core rv64_core_sva u_sva (
    .clk(clk), .reset(reset), .pc(pc), .bus_write_enable(bus_write_enable),
    .bus_read_enable(bus_read_enable), .interrupt_ack(interrupt_ack)
);

`default_nettype wire

//--- verification/rv64_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_core_tb;
    import rv64_pkg::*;

    logic            clk;
    logic            reset;
    logic [31:0]     instruction;
    logic [XLEN-1:0] pc;
    logic [31:0]     ir;
    logic            heartbeat;
    logic [3:0]      interrupt_vector;
    logic            interrupt_ack;
    logic [XLEN-1:0] bus_address;
    logic [XLEN-1:0] bus_write_data;
    logic            bus_write_enable;
    logic            bus_read_enable;
    logic [XLEN-1:0] bus_read_data;

    integer          seed;
    int              errors;
    int              checks;
    int              idx;                               // Next program slot
    int              ack_count;
    logic            re_prev;
    logic [31:0]     imem [0:127];                      // Word index from RAM_BASE
    logic [XLEN-1:0] dmem [logic [XLEN-1:0]];
    logic [XLEN-1:0] xr [0:31];                         // Reference register model
    logic [XLEN-1:0] wr_addr[$];
    logic [XLEN-1:0] wr_data[$];
    logic [XLEN-1:0] exp_addr[$];
    logic [XLEN-1:0] exp_data[$];
    logic [XLEN-1:0] rd_log[$];                         // Address at each read start

    rv64_core u_dut (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc), .ir(ir),
        .heartbeat(heartbeat), .interrupt_vector(interrupt_vector),
        .interrupt_ack(interrupt_ack), .bus_address(bus_address),
        .bus_write_data(bus_write_data), .bus_write_enable(bus_write_enable),
        .bus_read_enable(bus_read_enable), .bus_read_data(bus_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction port returns NOP outside the program window
    always @* begin
        if (pc >= RAM_BASE && pc < RAM_BASE + 64'd512) instruction = imem[(pc - RAM_BASE) >> 2];
        else instruction = NOP_INSN;
    end

    // Unwritten words read back an address pattern
    always @* begin
        if (dmem.exists(bus_address)) bus_read_data = dmem[bus_address];
        else bus_read_data = bus_address ^ 64'h5a5a_5a5a_5a5a_5a5a;
    end

    always @(posedge clk) begin
        if (reset === 1'b1 && bus_write_enable) begin
            dmem[bus_address] = bus_write_data;
            wr_addr.push_back(bus_address);
            wr_data.push_back(bus_write_data);
        end
        if (reset === 1'b1 && bus_read_enable && !re_prev) rd_log.push_back(bus_address);
        re_prev = bus_read_enable;
    end

    // Ack and trap vector are visible in the same cycle
    always @(negedge clk) begin
        if (reset === 1'b1 && interrupt_ack) begin
            ack_count++;
            check_value("pc at interrupt_ack", pc, MTVEC_RESET);
        end
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("Timeout at %0t ns: %s never happened", $time, what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    endtask

    // Instruction encoders
    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_type(input logic alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] sd_insn(input logic [11:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b011, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] jal_insn(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] beq_insn(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [XLEN-1:0] addr_of(input int slot);
        return RAM_BASE + 64'(4 * slot);
    endfunction

    // RV64I register-register semantics
    function automatic logic [XLEN-1:0] ref_alu(input logic alt, input logic [2:0] f3,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3:    return (a < b) ? 64'd1 : 64'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[idx] = word;
        idx++;
    endtask

    task automatic expect_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Random 32-bit constant via LUI then ADDI
    task automatic load_const(input logic [4:0] rd);
        logic [31:0] r;
        r = $random(seed);
        emit(u_type(r[31:12], rd, OPC_LUI));
        emit(i_type(r[11:0], rd, 3'b000, rd, OPC_OP_IMM));
        xr[rd] = {{32{r[31]}}, r[31:12], 12'b0} + sext12(r[11:0]);
    endtask

    // Hold reset and wipe program, memory and logs
    task automatic clear_program;
        @(negedge clk);
        reset = 1'b0;
        interrupt_vector = 4'd0;
        for (int i = 0; i < 128; i++) imem[i] = NOP_INSN;
        for (int i = 0; i < 32; i++) xr[i] = '0;
        idx = 0;
        ack_count = 0;
        dmem.delete();
        wr_addr.delete();
        wr_data.delete();
        exp_addr.delete();
        exp_data.delete();
        rd_log.delete();
    endtask

    task automatic release_reset;
        repeat (2) @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic check_writes;
        int n;
        n = 0;
        while (wr_addr.size() < exp_addr.size()) begin
            @(negedge clk);
            n++;
            if (n > 2000) abort_run("expected bus writes");
        end
        repeat (20) @(negedge clk);                     // Catch stray marker stores
        check_value("write count", wr_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < wr_addr.size(); i++) begin
            check_value("bus_address", wr_addr[i], exp_addr[i]);
            check_value("bus_write_data", wr_data[i], exp_data[i]);
        end
    endtask

    task automatic test_reset;
        logic prev;
        clear_program;
        emit(jal_insn(5'd0, 21'd0));
        repeat (2) begin
            @(negedge clk);
            check_value("pc", pc, RAM_BASE);
            check_value("ir", ir, NOP_INSN);
            check_value("bus_address", bus_address, RAM_BASE);
            check_value("bus_write_enable", bus_write_enable, 0);
            check_value("bus_read_enable", bus_read_enable, 0);
            check_value("interrupt_ack", interrupt_ack, 0);
            check_value("heartbeat", heartbeat, 0);
        end
        reset = 1'b1;
        prev = heartbeat;
        repeat (8) begin
            @(negedge clk);
            check_value("heartbeat", heartbeat, !prev);
            prev = heartbeat;
        end
    endtask

    task automatic test_arith;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] r;
        clear_program;
        load_const(5'd1);
        load_const(5'd2);
        emit(u_type(20'h1, 5'd10, OPC_LUI));           // Store base 0x1000
        xr[10] = 64'h1000;
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8);                             // SUB and SRA
            emit(r_type(alt, 5'd2, 5'd1, f3, 5'd3));
            emit(sd_insn(12'(8 * k), 5'd3, 5'd10));
            expect_write(xr[10] + 64'(8 * k), ref_alu(alt, f3, xr[1], xr[2]));
        end
        r = $random(seed);
        expect_write(xr[10] + 64'd80, addr_of(idx) + {{32{r[31]}}, r[31:12], 12'b0});
        emit(u_type(r[31:12], 5'd3, OPC_AUIPC));
        emit(sd_insn(12'd80, 5'd3, 5'd10));
        emit(jal_insn(5'd0, 21'd0));                    // Park
        release_reset;
        check_writes;
    endtask

    task automatic test_load_store;
        clear_program;
        load_const(5'd1);
        load_const(5'd2);
        emit(u_type(20'h1, 5'd10, OPC_LUI));
        emit(sd_insn(12'd0, 5'd1, 5'd10));
        emit(sd_insn(12'd8, 5'd2, 5'd10));
        emit(i_type(12'd0, 5'd10, 3'b011, 5'd4, OPC_LOAD));
        emit(i_type(12'd8, 5'd10, 3'b011, 5'd5, OPC_LOAD));
        emit(sd_insn(12'd16, 5'd4, 5'd10));             // Copies of the loaded words
        emit(sd_insn(12'd24, 5'd5, 5'd10));
        emit(jal_insn(5'd0, 21'd0));
        expect_write(64'h1000, xr[1]);
        expect_write(64'h1008, xr[2]);
        expect_write(64'h1010, xr[1]);
        expect_write(64'h1018, xr[2]);
        release_reset;
        check_writes;
        check_value("read count", rd_log.size(), 2);
        if (rd_log.size() == 2) begin
            check_value("load bus_address", rd_log[0], 64'h1000);
            check_value("load bus_address", rd_log[1], 64'h1008);
        end
        check_value("memory at 1010", dmem[64'h1010], xr[1]);
        check_value("memory at 1018", dmem[64'h1018], xr[2]);
    endtask

    task automatic test_control;
        clear_program;
        emit(u_type(20'h1, 5'd10, OPC_LUI));
        emit(jal_insn(5'd1, 21'd8));                    // Skips slot 2
        emit(sd_insn(12'h100, 5'd10, 5'd10));           // Marker
        emit(sd_insn(12'd0, 5'd1, 5'd10));
        emit(u_type(20'h0, 5'd5, OPC_AUIPC));
        emit(i_type(12'd12, 5'd5, 3'b000, 5'd2, OPC_JALR));   // To slot 7
        emit(sd_insn(12'h100, 5'd10, 5'd10));           // Marker
        emit(sd_insn(12'd8, 5'd2, 5'd10));
        emit(beq_insn(5'd0, 5'd0, 13'd8));              // Taken
        emit(sd_insn(12'h100, 5'd10, 5'd10));           // Marker
        emit(beq_insn(5'd1, 5'd0, 13'd8));              // x1 nonzero so untaken
        emit(sd_insn(12'd16, 5'd10, 5'd10));
        emit(jal_insn(5'd0, 21'd0));
        expect_write(64'h1000, addr_of(2));             // JAL link
        expect_write(64'h1008, addr_of(6));             // JALR link
        expect_write(64'h1010, 64'h1000);
        release_reset;
        check_writes;
    endtask

    task automatic test_interrupt;
        int n;
        clear_program;
        emit(u_type(20'h1, 5'd10, OPC_LUI));
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        emit(beq_insn(5'd7, 5'd0, 13'd0));              // Spin until handler sets x7
        emit(sd_insn(12'd32, 5'd10, 5'd10));            // Proves the return
        emit(jal_insn(5'd0, 21'd0));
        idx = 64;                                       // MTVEC_RESET slot
        emit(i_type(CSR_MEPC, 5'd0, 3'b010, 5'd5, OPC_SYSTEM));
        emit(i_type(CSR_MCAUSE, 5'd0, 3'b010, 5'd6, OPC_SYSTEM));
        emit(sd_insn(12'd0, 5'd5, 5'd10));
        emit(sd_insn(12'd8, 5'd6, 5'd10));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        emit(NOP_INSN);
        emit(32'h3020_0073);                            // MRET
        expect_write(64'h1000, addr_of(2));
        expect_write(64'h1008, CAUSE_MEXT);
        expect_write(64'h1020, 64'h1000);
        release_reset;
        n = 0;
        while (pc !== addr_of(2)) begin
            @(negedge clk);
            n++;
            if (n > 200) abort_run("entry into the wait loop");
        end
        repeat (5) @(negedge clk);
        interrupt_vector = IRQ_MEXT;
        n = 0;
        while (ack_count == 0) begin
            @(negedge clk);
            n++;
            if (n > 200) abort_run("interrupt_ack");
        end
        // Request stays high in the handler while MIE is clear
        n = 0;
        while (wr_addr.size() < 2) begin
            @(negedge clk);
            n++;
            if (n > 200) abort_run("handler stores");
        end
        @(negedge clk);
        interrupt_vector = 4'd0;
        n = 0;
        while (ir !== 32'h3020_0073) begin
            @(negedge clk);
            n++;
            if (n > 200) abort_run("MRET in ir");
        end
        @(negedge clk);
        check_value("pc after MRET", pc, addr_of(2));   // Bubble holds the return target
        @(negedge clk);
        check_value("ir after MRET", ir, beq_insn(5'd7, 5'd0, 13'd0));
        check_writes;
        check_value("interrupt_ack count", ack_count, 1);
    endtask

    initial begin
        seed = 32'hd440_24cb;
        errors = 0;
        checks = 0;
        reset = 1'b0;
        interrupt_vector = 4'd0;
        re_prev = 1'b0;
        idx = 0;
        ack_count = 0;
        test_reset;
        test_arith;
        test_load_store;
        test_control;
        test_interrupt;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
